// ==== list.f ====
verilog/snake_pkg.sv
verilog/segment_ram.sv
verilog/dir_register.sv
verilog/snake_datapath.sv
verilog/snake_control.sv
verilog/snake_top.sv
dv/snake_checker.sv
dv/snake_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = snake_tb
FILELIST = list.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the snake testbench with Verilator"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/snake_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_tb
	import snake_pkg::*;
();

	// step pulses issued below, ignored ones included
	localparam int NUM_STEPS = 34;
	localparam int MAX_CYCLES = NUM_STEPS * (5 * SNAKE_LEN + 10) + 200;

	logic clk = 1'b0;
	logic rst;
	logic start;
	logic step;
	logic [3:0] dir_btn;
	logic plot_en, colour, busy, dead;
	logic [X_W-1:0] x;
	logic [Y_W-1:0] y;

	// model state, body[0] is the head
	logic [POS_W-1:0] body [$];
	logic [POS_W:0] exp_pix [$];
	dir_t model_dir;
	logic model_dead;
	int seed = 33;
	int value_errors = 0;
	int other_errors = 0;
	int assert_errors = 0;
	int cycles = 0;

	// first pixel plotted by the latest walk
	logic [POS_W-1:0] first_block;

	always #5 clk = ~clk;

	snake_top i_snake_top (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.step    (step),
		.dir_btn (dir_btn),
		.plot_en (plot_en),
		.colour  (colour),
		.x       (x),
		.y       (y),
		.busy    (busy),
		.dead    (dead)
	);

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout after %0d cycles, a step walk never finished", cycles);
			$display("Simulation FAILED");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] want);
		assert (got == want) else begin
			value_errors++;
			$display("FAILED %s: expected %h, got %h", name, want, got);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic dir_t opposite(input dir_t d);
		case (d)
			DIR_UP:   opposite = DIR_DOWN;
			DIR_DOWN: opposite = DIR_UP;
			DIR_LEFT: opposite = DIR_RIGHT;
			default:  opposite = DIR_LEFT;
		endcase
	endfunction

	function automatic dir_t button_dir(input int idx);
		case (idx)
			0:       button_dir = DIR_UP;
			1:       button_dir = DIR_DOWN;
			2:       button_dir = DIR_LEFT;
			default: button_dir = DIR_RIGHT;
		endcase
	endfunction

	function automatic logic [POS_W-1:0] moved(input logic [POS_W-1:0] pos, input dir_t d);
		logic [X_W-1:0] px;
		logic [Y_W-1:0] py;
		px = pos[POS_W-1:Y_W];
		py = pos[Y_W-1:0];
		case (d)
			DIR_UP:   py = py - 1'b1;
			DIR_DOWN: py = py + 1'b1;
			DIR_LEFT: px = px - 1'b1;
			default:  px = px + 1'b1;
		endcase
		moved = {px, py};
	endfunction

	// the head never collides with itself, segments 1 and up count
	function automatic logic lands_on_body(input logic [POS_W-1:0] pos);
		lands_on_body = 1'b0;
		for (int i = 1; i < SNAKE_LEN; i++)
			if (body[i] == pos)
				lands_on_body = 1'b1;
	endfunction

	function automatic int safe_button(input int first);
		dir_t d;
		safe_button = -1;
		for (int k = 3; k >= 0; k--) begin
			d = button_dir((first + k) % 4);
			if (d != opposite(model_dir) && !lands_on_body(moved(body[0], d)))
				safe_button = (first + k) % 4;
		end
	endfunction

	task automatic push_block(input logic [POS_W-1:0] pos, input logic col);
		for (int p = 0; p < 4; p++)
			exp_pix.push_back({col, pos[POS_W-1:Y_W] + X_W'(p / 2),
				pos[Y_W-1:0] + Y_W'(p % 2)});
	endtask

	task automatic model_step();
		logic [POS_W-1:0] new_head;
		logic [POS_W-1:0] tail;
		new_head = moved(body[0], model_dir);
		if (lands_on_body(new_head))
			model_dead = 1'b1;
		tail = body[SNAKE_LEN-1];
		body.push_front(new_head);
		body.delete(SNAKE_LEN);
		for (int i = 0; i < SNAKE_LEN; i++)
			push_block(body[i], 1'b1);
		push_block(tail, 1'b0);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and pixel compare
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(negedge clk) begin
		logic [POS_W:0] want;
		if (rst && plot_en) begin
			assert (exp_pix.size() > 0) else begin
				other_errors++;
				$display("pixel at x %h y %h plotted when none was expected", x, y);
			end
			if (exp_pix.size() > 0) begin
				want = exp_pix.pop_front();
				check_value("x", x, want[POS_W-1:Y_W]);
				check_value("y", y, want[Y_W-1:0]);
				check_value("colour", colour, want[POS_W]);
			end
		end
	end

	task automatic restart();
		@(posedge clk);
		#1 start = 1'b1;
		@(posedge clk);
		#1 start = 1'b0;
		body.delete();
		for (int i = 0; i < SNAKE_LEN; i++)
			body.push_back({DEF_X, DEF_Y + Y_W'(i)});
		model_dir = RESET_DIR;
		model_dead = 1'b0;
		while (busy) begin
			@(posedge clk);
			#1;
		end
		check_value("dead", dead, 1'b0);
	endtask

	task automatic press(input int idx);
		dir_t req;
		req = button_dir(idx);
		@(posedge clk);
		#1 dir_btn = 4'b0001 << idx;
		@(posedge clk);
		#1 dir_btn = 4'b0000;
		if (req != opposite(model_dir))
			model_dir = req;
	endtask

	task automatic run_step(input int extra);
		logic accepted;
		logic seen;
		accepted = !model_dead;
		seen = 1'b0;
		@(posedge clk);
		#1 step = 1'b1;
		@(posedge clk);
		#1 step = 1'b0;
		if (accepted)
			model_step();
		// these land while the walk is running
		for (int i = 0; i < extra; i++) begin
			@(posedge clk);
			#1 step = 1'b1;
			@(posedge clk);
			#1 step = 1'b0;
		end
		while (busy) begin
			if (plot_en && !seen) begin
				first_block = {x, y};
				seen = 1'b1;
			end
			@(posedge clk);
			#1;
		end
		assert (exp_pix.size() == 0) else begin
			other_errors++;
			$display("busy fell with %0d pixels still missing", exp_pix.size());
			exp_pix.delete();
		end
		check_value("dead", dead, model_dead);
	endtask

	initial begin
		int pick;
		int choice;
		rst = 1'b0;
		start = 1'b0;
		step = 1'b0;
		dir_btn = 4'b0000;
		repeat (2) @(posedge clk);
		#1 rst = 1'b1;
		check_value("plot_en", plot_en, 1'b0);
		check_value("busy", busy, 1'b0);
		check_value("dead", dead, 1'b0);
		check_value("colour", colour, 1'b0);

		restart();
		run_step(0);
		// the walk opens with the new head one row above the start
		check_value("x", first_block[POS_W-1:Y_W], DEF_X);
		check_value("y", first_block[Y_W-1:0], DEF_Y - 7'd1);
		run_step(0);
		run_step(0);

		// down while heading up is refused
		press(1);
		run_step(0);
		for (int n = 0; n < 20; n++) begin
			pick = $unsigned($random(seed)) % 4;
			choice = safe_button(pick);
			if (choice >= 0)
				press(choice);
			run_step(0);
		end
		run_step(3);

		// right, down, left curls the head back into the body
		restart();
		press(3);
		run_step(0);
		press(1);
		run_step(0);
		press(2);
		run_step(0);
		press(0);
		run_step(0);
		run_step(0);
		restart();
		run_step(0);

		assert_errors = i_snake_top.i_snake_checker.fail_count;
		$display("errors: %0d value, %0d other, %0d assertion",
			value_errors, other_errors, assert_errors);
		if (value_errors + other_errors + assert_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/snake_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_checker
	import snake_pkg::*;
(
	input logic           clk,
	input logic           rst,
	input logic           start,
	input logic           step,
	input logic           plot_en,
	input logic           colour,
	input logic [X_W-1:0] x,
	input logic [Y_W-1:0] y,
	input logic [1:0]     pix,
	input logic           busy,
	input logic           dead
);

	int fail_count = 0;

	// pixels only come out of a running walk
	a_plot_busy: assert property (@(posedge clk) disable iff (!rst) plot_en |-> busy)
		else begin
			fail_count++;
			$error("plot_en high while busy is low");
		end

	a_step_busy: assert property (@(posedge clk) disable iff (!rst)
		step && !busy && !dead |=> busy)
		else begin
			fail_count++;
			$error("accepted step did not raise busy");
		end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// 2x2 block shape
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	a_pix_01: assert property (@(posedge clk) disable iff (!rst)
		plot_en && pix == 2'd0 |=> plot_en && pix == 2'd1 && x == $past(x)
		&& y == Y_W'($past(y) + 1'b1) && colour == $past(colour))
		else begin
			fail_count++;
			$error("second pixel of a block is not below the first");
		end

	a_pix_10: assert property (@(posedge clk) disable iff (!rst)
		plot_en && pix == 2'd1 |=> plot_en && pix == 2'd2 && x == X_W'($past(x) + 1'b1)
		&& y == Y_W'($past(y) - 1'b1) && colour == $past(colour))
		else begin
			fail_count++;
			$error("third pixel of a block is not right of the first");
		end

	a_pix_11: assert property (@(posedge clk) disable iff (!rst)
		plot_en && pix == 2'd2 |=> plot_en && pix == 2'd3 && x == $past(x)
		&& y == Y_W'($past(y) + 1'b1) && colour == $past(colour))
		else begin
			fail_count++;
			$error("last pixel of a block is not the lower right corner");
		end

	a_dead_sticky: assert property (@(posedge clk) disable iff (!rst)
		$fell(dead) |-> $past(start))
		else begin
			fail_count++;
			$error("dead fell without a start");
		end

endmodule

bind snake_top snake_checker i_snake_checker (
	.clk     (clk),
	.rst     (rst),
	.start   (start),
	.step    (step),
	.plot_en (plot_en),
	.colour  (colour),
	.x       (x),
	.y       (y),
	.pix     (pix),
	.busy    (busy),
	.dead    (dead)
);

`default_nettype wire

// ==== verilog/snake_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_top
	import snake_pkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  logic           start,
	input  logic           step,
	input  logic [3:0]     dir_btn,
	output logic           plot_en,
	output logic           colour,
	output logic [X_W-1:0] x,
	output logic [Y_W-1:0] y,
	output logic           busy,
	output logic           dead
);

	dir_t cur_dir;
	logic seg_init, move_head, ld_head_prev, ld_q_curr, ld_curr_prev, wr_prev;
	logic draw_curr, draw_prev, erase, addr_inc, addr_clr;
	logic [1:0] pix;
	logic hit, last_seg;

	dir_register i_dir_register (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.dir_btn (dir_btn),
		.cur_dir (cur_dir)
	);

	snake_control i_snake_control (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.step         (step),
		.hit          (hit),
		.last_seg     (last_seg),
		.seg_init     (seg_init),
		.move_head    (move_head),
		.ld_head_prev (ld_head_prev),
		.ld_q_curr    (ld_q_curr),
		.ld_curr_prev (ld_curr_prev),
		.wr_prev      (wr_prev),
		.draw_curr    (draw_curr),
		.draw_prev    (draw_prev),
		.erase        (erase),
		.addr_inc     (addr_inc),
		.addr_clr     (addr_clr),
		.pix          (pix),
		.busy         (busy),
		.dead         (dead)
	);

	snake_datapath i_snake_datapath (
		.clk          (clk),
		.rst          (rst),
		.cur_dir      (cur_dir),
		.seg_init     (seg_init),
		.move_head    (move_head),
		.ld_head_prev (ld_head_prev),
		.ld_q_curr    (ld_q_curr),
		.ld_curr_prev (ld_curr_prev),
		.wr_prev      (wr_prev),
		.draw_curr    (draw_curr),
		.draw_prev    (draw_prev),
		.erase        (erase),
		.addr_inc     (addr_inc),
		.addr_clr     (addr_clr),
		.pix          (pix),
		.hit          (hit),
		.last_seg     (last_seg),
		.plot_en      (plot_en),
		.colour       (colour),
		.x            (x),
		.y            (y)
	);

endmodule

`default_nettype wire

// ==== verilog/snake_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_control (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic       step,
	input  logic       hit,
	input  logic       last_seg,
	output logic       seg_init,
	output logic       move_head,
	output logic       ld_head_prev,
	output logic       ld_q_curr,
	output logic       ld_curr_prev,
	output logic       wr_prev,
	output logic       draw_curr,
	output logic       draw_prev,
	output logic       erase,
	output logic       addr_inc,
	output logic       addr_clr,
	output logic [1:0] pix,
	output logic       busy,
	output logic       dead
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_INIT,
		ST_MOVE,
		ST_READ,
		ST_LOAD,
		ST_DRAW,
		ST_ERASE,
		ST_DONE
	} state_t;

	state_t state, next_state;
	logic [1:0] pix_cnt;
	logic step_ok;

	assign step_ok = step && !dead;
	assign pix = pix_cnt;
	assign busy = (state != ST_IDLE) && (state != ST_DONE);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// state sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE:  if (step_ok) next_state = ST_MOVE;
			ST_INIT:  if (last_seg) next_state = ST_IDLE;
			ST_MOVE:  next_state = ST_READ;
			ST_READ:  next_state = ST_LOAD;
			ST_LOAD:  next_state = ST_DRAW;
			ST_DRAW: begin
				if (pix_cnt == 2'd3)
					next_state = last_seg ? ST_ERASE : ST_READ;
			end
			ST_ERASE: if (pix_cnt == 2'd3) next_state = ST_DONE;
			ST_DONE:  next_state = step_ok ? ST_MOVE : ST_IDLE;
			default:  next_state = ST_IDLE;
		endcase
		// a start restarts the game from any state
		if (start)
			next_state = ST_INIT;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			state <= ST_IDLE;
		else
			state <= next_state;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			pix_cnt <= 2'd0;
		else if (start)
			pix_cnt <= 2'd0;
		else if (state == ST_DRAW || state == ST_ERASE)
			pix_cnt <= pix_cnt + 2'd1;
	end

	// the walk goes on after a hit, only the flag is kept
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			dead <= 1'b0;
		else if (start)
			dead <= 1'b0;
		else if (state == ST_LOAD && hit)
			dead <= 1'b1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath strobes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		seg_init = 1'b0;
		move_head = 1'b0;
		ld_head_prev = 1'b0;
		ld_q_curr = 1'b0;
		ld_curr_prev = 1'b0;
		wr_prev = 1'b0;
		draw_curr = 1'b0;
		draw_prev = 1'b0;
		erase = 1'b0;
		addr_inc = 1'b0;
		addr_clr = 1'b0;
		case (state)
			ST_INIT: begin
				seg_init = 1'b1;
				addr_inc = !last_seg;
				addr_clr = last_seg;
			end
			ST_MOVE: begin
				move_head = 1'b1;
				ld_head_prev = 1'b1;
			end
			ST_LOAD: begin
				ld_q_curr = 1'b1;
				wr_prev = 1'b1;
			end
			ST_DRAW: begin
				draw_prev = 1'b1;
				// the last segment stays in curr for the tail erase
				if (pix_cnt == 2'd3 && !last_seg) begin
					ld_curr_prev = 1'b1;
					addr_inc = 1'b1;
				end
			end
			ST_ERASE: begin
				draw_curr = 1'b1;
				erase = 1'b1;
			end
			ST_DONE:  addr_clr = 1'b1;
			default:  addr_clr = 1'b0;
		endcase
		if (start)
			addr_clr = 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/snake_datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module snake_datapath
	import snake_pkg::*;
(
	input  logic           clk,
	input  logic           rst,
	input  dir_t           cur_dir,
	input  logic           seg_init,
	input  logic           move_head,
	input  logic           ld_head_prev,
	input  logic           ld_q_curr,
	input  logic           ld_curr_prev,
	input  logic           wr_prev,
	input  logic           draw_curr,
	input  logic           draw_prev,
	input  logic           erase,
	input  logic           addr_inc,
	input  logic           addr_clr,
	input  logic [1:0]     pix,
	output logic           hit,
	output logic           last_seg,
	output logic           plot_en,
	output logic           colour,
	output logic [X_W-1:0] x,
	output logic [Y_W-1:0] y
);

	logic [SEG_AW-1:0] addr;
	logic [POS_W-1:0]  head, next_head;
	logic [POS_W-1:0]  curr, prev;
	logic [POS_W-1:0]  def_pos, sel_pos;
	logic [POS_W-1:0]  ram_wdata, ram_rdata;
	logic              ram_wren;

	segment_ram i_segment_ram (
		.clk   (clk),
		.addr  (addr),
		.wdata (ram_wdata),
		.wren  (ram_wren),
		.rdata (ram_rdata)
	);

	// default column, one row further down per segment
	assign def_pos = {DEF_X, DEF_Y + Y_W'(addr)};

	assign ram_wren = seg_init | wr_prev;
	assign ram_wdata = seg_init ? def_pos : prev;

	always_comb begin
		next_head = head;
		case (cur_dir)
			DIR_UP:    next_head[Y_W-1:0] = head[Y_W-1:0] - 1'b1;
			DIR_DOWN:  next_head[Y_W-1:0] = head[Y_W-1:0] + 1'b1;
			DIR_LEFT:  next_head[POS_W-1:Y_W] = head[POS_W-1:Y_W] - 1'b1;
			DIR_RIGHT: next_head[POS_W-1:Y_W] = head[POS_W-1:Y_W] + 1'b1;
			default:   next_head = head;
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			addr <= '0;
		else if (addr_clr)
			addr <= '0;
		else if (addr_inc)
			addr <= addr + 1'b1;
	end

	// prev starts out as the moved head so that segment 0 receives it
	always_ff @(posedge clk) begin
		if (seg_init && addr == '0)
			head <= def_pos;
		else if (move_head)
			head <= next_head;
		if (ld_head_prev)
			prev <= next_head;
		else if (ld_curr_prev)
			prev <= curr;
		if (ld_q_curr)
			curr <= ram_rdata;
	end

	// the segment at address 0 is the old head and never counts as a hit
	assign hit = (ram_rdata == head) && (addr != '0);
	assign last_seg = (addr == SEG_AW'(SNAKE_LEN - 1));

	// body blocks come from prev, the old tail left over in curr is erased
	always_comb begin
		plot_en = draw_prev | draw_curr;
		colour = plot_en & ~erase;
		sel_pos = draw_curr ? curr : prev;
		x = '0;
		y = '0;
		if (plot_en) begin
			x = sel_pos[POS_W-1:Y_W] + X_W'(pix[1]);
			y = sel_pos[Y_W-1:0] + Y_W'(pix[0]);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dir_register.sv ====
`timescale 1ns/1ns
`default_nettype none

module dir_register
	import snake_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic [3:0] dir_btn,
	output dir_t       cur_dir
);

	dir_t req_dir;
	dir_t rev_dir;
	logic req_valid;

	// bit 0 is up, then down, left and right, the lowest pressed bit wins
	always_comb begin
		req_valid = 1'b1;
		req_dir = DIR_UP;
		if (dir_btn[0])
			req_dir = DIR_UP;
		else if (dir_btn[1])
			req_dir = DIR_DOWN;
		else if (dir_btn[2])
			req_dir = DIR_LEFT;
		else if (dir_btn[3])
			req_dir = DIR_RIGHT;
		else
			req_valid = 1'b0;
	end

	assign rev_dir = dir_t'({cur_dir[1], ~cur_dir[0]});

	// turning back onto the body is simply not taken
	always_ff @(posedge clk or negedge rst) begin
		if (!rst)
			cur_dir <= RESET_DIR;
		else if (start)
			cur_dir <= RESET_DIR;
		else if (req_valid && req_dir != rev_dir)
			cur_dir <= req_dir;
	end

endmodule

`default_nettype wire

// ==== verilog/segment_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module segment_ram
	import snake_pkg::*;
(
	input  logic             clk,
	input  logic [SEG_AW-1:0] addr,
	input  logic [POS_W-1:0]  wdata,
	input  logic             wren,
	output logic [POS_W-1:0]  rdata
);

	logic [POS_W-1:0] mem [SNAKE_LEN];

	// one word per segment, read data appears one cycle after the address
	always_ff @(posedge clk) begin
		if (wren) begin
			mem[addr] <= wdata;
			// write-through so the output follows the word just stored
			rdata <= wdata;
		end
		else begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== verilog/snake_pkg.sv ====
`default_nettype none

package snake_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// playfield geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int X_W = 8;
	localparam int Y_W = 7;

	// a position packs x in the upper bits and y in the lower bits
	localparam int POS_W = X_W + Y_W;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// snake body
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// segment 0 is the head
	localparam int SNAKE_LEN = 8;
	localparam int SEG_AW = 3;

	// the head starts here and the body hangs straight down below it
	localparam logic [X_W-1:0] DEF_X = 8'd60;
	localparam logic [Y_W-1:0] DEF_Y = 7'd60;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// heading
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// opposite headings differ only in bit 0
	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_t;

	// up leads away from the body after a start
	localparam dir_t RESET_DIR = DIR_UP;

endpackage

`default_nettype wire
